//--- sim.f
src/fas_pkg.sv
src/fir_filter.sv
src/frame_collector.sv
src/fas_top.sv
dv/fas_asserts.sv
dv/fas_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module fas_tb -f sim.f

output=$(./obj_dir/Vfas_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Done: no errors'; then
  exit 0
fi
exit 1

//--- dv/fas_tb.sv
module fas_tb import fas_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_BURSTS       = 12;
  localparam int MAX_BURST      = 120;
  localparam int MAX_GAP        = 8;
  localparam int DRAIN_CYCLES   = 24;   // Lets the last frame finish and the framer idle
  localparam int TIMEOUT_CYCLES = N_BURSTS * (MAX_BURST + MAX_GAP) + 100;

  logic    clk;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    frame_valid;
  frame_t  frame;

  int      seed;
  int      cycle_cnt;

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////

  sample_t      m_hist [$];   // Front is the newest sample
  longint       m_sum;
  int           m_fill;
  frame_state_e m_state;
  frame_idx_t   m_idx;
  logic         m_done;       // Word 15 landed on the last edge
  frame_t       m_frame;
  logic         m_in_valid;   // Inputs the DUT samples on the next edge
  sample_t      m_in_data;

  fas_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $fatal(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Model
  //////////////////////////////////////////////////

  // Sign bit over the integer bits, then one up if negative (round toward zero)
  function automatic sample_t narrow_sum(input longint s);
    logic    neg;
    sample_t n;
    neg = (s < 0);
    n   = {neg, s[30:16]};
    if (neg) begin
      n = n + sample_t'(1);
    end
    return n;
  endfunction

  function automatic longint dot_product();
    longint acc;
    acc = 0;
    for (int i = 0; i < N_TAPS; i++) begin
      acc += longint'(m_hist[i]) * longint'(fir_coefs[i]);  // Newest sample meets coefficient 0
    end
    return acc;
  endfunction

  function automatic void reset_model();
    m_hist.delete();
    for (int i = 0; i < N_TAPS; i++) begin
      m_hist.push_back('0);
    end
    m_sum      = 0;
    m_fill     = 0;
    m_state    = FRAME_IDLE;
    m_idx      = '0;
    m_done     = 1'b0;
    m_frame    = '0;
    m_in_valid = 1'b0;
    m_in_data  = '0;
  endfunction

  // One active clock edge. The framer sees the filter outputs from before the edge
  function automatic void step_model();
    logic    fv;
    sample_t fd;
    fv = (m_fill == FILL_CYCLES);
    fd = narrow_sum(m_sum);
    if (m_state == FRAME_IDLE) begin
      m_done = 1'b0;
      if (fv) begin
        m_frame[m_idx] = fd;
        m_idx          = m_idx + 1'b1;
        m_state        = FRAME_FILL;
      end
    end else if (m_done && !fv) begin
      m_done  = 1'b0;
      m_state = FRAME_IDLE;            // Filter went quiet, no chained frame
    end else begin
      m_frame[m_idx] = fd;
      m_done         = (m_idx == frame_idx_t'(FRAME_LEN - 1));
      m_idx          = m_idx + 1'b1;
    end
    if (m_in_valid) begin
      m_sum = dot_product();
      m_hist.push_front(m_in_data);
      void'(m_hist.pop_back());
      if (m_fill < FILL_CYCLES) begin
        m_fill++;
      end
    end else begin
      m_sum  = 0;                      // History holds across the gap
      m_fill = 0;
    end
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("error: %s expected %0d actual %0d (cycle %0d)",
               name, expected, actual, cycle_cnt);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic check_outputs();
    sample_t exp_w;
    sample_t act_w;
    if (i_dut.u_asserts.n_failed != 0) begin
      $display("a bound assertion on the filter or framer failed by cycle %0d", cycle_cnt);
      $display("Done: errors found");
      $fatal(1);
    end
    check_value("fir_valid", longint'(m_fill == FILL_CYCLES), longint'(fir_valid));
    check_value("fir_d", longint'(narrow_sum(m_sum)), longint'(fir_d));
    check_value("frame_valid", longint'(m_done), longint'(frame_valid));
    if (m_done) begin
      for (int w = 0; w < FRAME_LEN; w++) begin
        exp_w = m_frame[frame_idx_t'(w)];
        act_w = frame[frame_idx_t'(w)];
        check_value($sformatf("frame word %0d", w), longint'(exp_w), longint'(act_w));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic run_cycle(input logic valid, input sample_t value);
    @(posedge clk);
    step_model();
    data_valid <= valid;
    data       <= value;
    m_in_valid = valid;
    m_in_data  = value;
    @(negedge clk);
    check_outputs();                   // Outputs settled half a period after the edge
  endtask

  // Burst 0 is long enough to chain frames, burst 3 never fills the pipeline
  function automatic int burst_length(input int b);
    int span;
    span = int'($unsigned($random(seed)) % (MAX_BURST - 19));
    if (b == 0) begin
      return 100 + span % 21;
    end
    if (b == 3) begin
      return 20 + span % 14;
    end
    return 20 + span;
  endfunction

  initial begin
    int n_valid;
    int n_idle;
    seed       = 32'hdb8f_4b41;
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    reset_model();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_outputs();
    for (int b = 0; b < N_BURSTS; b++) begin
      n_valid = burst_length(b);
      n_idle  = 1 + int'($unsigned($random(seed)) % MAX_GAP);
      repeat (n_valid) run_cycle(1'b1, sample_t'($random(seed)));
      repeat (n_idle) run_cycle(1'b0, sample_t'($random(seed)));  // Data ignored in gaps
    end
    repeat (DRAIN_CYCLES) run_cycle(1'b0, '0);
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- dv/fas_asserts.sv
module fas_asserts import fas_pkg::*; (
  input logic clk,
  input logic rst,
  input logic data_valid,
  input logic fir_valid,
  input logic frame_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned n_failed = 0;   // Failed assertion count

  // An idle input cycle clears the fill count on the next edge
  fir_valid_drop: assert property (
    @(posedge clk) disable iff (rst) !data_valid |=> !fir_valid
  ) else begin
    n_failed++;
    $error("fir_valid still high one edge after idle input");
  end

  // A frame takes sixteen writes, so pulses never touch
  frame_pulse_single: assert property (
    @(posedge clk) disable iff (rst) frame_valid |=> !frame_valid
  ) else begin
    n_failed++;
    $error("frame_valid high on two consecutive cycles");
  end

  // Filter still valid at a pulse means the next frame is already under way
  frame_chain: assert property (
    @(posedge clk) disable iff (rst) $past(frame_valid && fir_valid, FRAME_LEN) |-> frame_valid
  ) else begin
    n_failed++;
    $error("chained frame did not complete one frame length later");
  end

  strobes_in_reset: assert property (
    @(posedge clk) rst |-> !fir_valid && !frame_valid
  ) else begin
    n_failed++;
    $error("strobe high while reset is asserted");
  end

endmodule

// Top level carries the filter and framer strobes side by side
bind fas_top fas_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .data_valid  (data_valid),
  .fir_valid   (fir_valid),
  .frame_valid (frame_valid)
);

//--- src/fas_top.sv
module fas_top import fas_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,
  input  sample_t data,
  output logic    fir_valid,
  output sample_t fir_d,
  output logic    frame_valid,
  output frame_t  frame
);

  //////////////////////////////////////////////////
  // Filter
  //////////////////////////////////////////////////

  // Its outputs leave the chip and also feed the framer
  fir_filter u_fir (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  //////////////////////////////////////////////////
  // Framer
  //////////////////////////////////////////////////

  frame_collector u_framer (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),   // Plain level, no back-pressure
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

endmodule

//--- src/frame_collector.sv
module frame_collector import fas_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    fir_valid,
  input  sample_t fir_d,
  output logic    frame_valid,
  output frame_t  frame
);

  frame_state_e state;
  frame_state_e state_next;
  frame_idx_t   idx;         // Next word to write
  logic         wr_en;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  // In FILL the index only returns to zero right after word 15 lands
  assign frame_valid = (state == FRAME_FILL) && (idx == '0);

  always_comb begin
    state_next = state;
    wr_en      = 1'b0;
    case (state)
      FRAME_IDLE: begin
        if (fir_valid) begin
          wr_en      = 1'b1;       // Word 0 of a fresh frame
          state_next = FRAME_FILL;
        end
      end
      FRAME_FILL: begin
        if (idx != '0 || fir_valid) begin
          wr_en = 1'b1;            // Mid-frame words ignore fir_valid
        end else begin
          state_next = FRAME_IDLE; // Frame done and the filter has gone quiet
        end
      end
      default: begin
        state_next = FRAME_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Index and frame storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= FRAME_IDLE;
      idx   <= '0;
      frame <= '0;
    end else begin
      state <= state_next;
      if (wr_en) begin
        frame[idx] <= fir_d;
        idx        <= idx + 1'b1;  // Wraps after word 15
      end
    end
  end

endmodule

//--- src/fir_filter.sv
module fir_filter import fas_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,
  input  sample_t data,
  output logic    fir_valid,
  output sample_t fir_d
);

  sample_t   taps [N_TAPS];   // Entry 0 is the newest sample
  acc_t      sum_next;
  acc_t      sum_r;
  fill_cnt_t fill_cnt;
  sample_t   narrow;          // Sign bit over the integer part of the sum
  logic      sum_neg;

  //////////////////////////////////////////////////
  // Tap delay line
  //////////////////////////////////////////////////

  // Shifts only on valid input, so history survives a gap
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < N_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (data_valid) begin
      taps[0] <= data;
      for (int i = 1; i < N_TAPS; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // Multiply-accumulate
  //////////////////////////////////////////////////

  // Dot product over the line as it stands before this edge's shift
  always_comb begin
    sum_next = '0;
    for (int i = 0; i < N_TAPS; i++) begin
      sum_next = sum_next + acc_t'(taps[i]) * acc_t'(fir_coefs[i]);  // Sign-extended operands
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum_r <= '0;
    end else if (data_valid) begin
      sum_r <= sum_next;
    end else begin
      sum_r <= '0;              // Output reads zero during a gap
    end
  end

  //////////////////////////////////////////////////
  // Fill counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt <= '0;
    end else if (!data_valid) begin
      fill_cnt <= '0;           // Any idle cycle restarts the run
    end else if (fill_cnt != fill_cnt_t'(FILL_CYCLES)) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  assign fir_valid = (fill_cnt == fill_cnt_t'(FILL_CYCLES));  // Saturated count

  //////////////////////////////////////////////////
  // Output narrowing
  //////////////////////////////////////////////////

  assign sum_neg = sum_r[ACC_W-1];
  assign narrow  = {sum_neg, sum_r[FRAC_BITS+SAMPLE_W-2:FRAC_BITS]};

  // Bumping negative results by one moves the truncation toward zero
  assign fir_d = sum_neg ? narrow + sample_t'(1) : narrow;

endmodule

//--- src/fas_pkg.sv
package fas_pkg;

  //////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////

  localparam int SAMPLE_W    = 16;  // Input and filtered samples
  localparam int COEF_W      = 20;  // Q4.16 coefficients
  localparam int FRAC_BITS   = 16;
  localparam int ACC_W       = 42;  // 36-bit products, 32 of them, plus headroom
  localparam int N_TAPS      = 32;
  localparam int FILL_CYCLES = 34;  // Valid run before the output is trusted
  localparam int FRAME_LEN   = 16;

  localparam int FILL_CNT_W  = $clog2(FILL_CYCLES + 1);
  localparam int IDX_W       = $clog2(FRAME_LEN);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEF_W-1:0]   coef_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef sample_t [FRAME_LEN-1:0]    frame_t;     // Word 0 in the low bits

  typedef logic [FILL_CNT_W-1:0]      fill_cnt_t;
  typedef logic [IDX_W-1:0]           frame_idx_t;

  typedef enum logic {
    FRAME_IDLE,   // Waiting for the filter output to become valid
    FRAME_FILL    // Collecting words, one per cycle
  } frame_state_e;

  //////////////////////////////////////////////////
  // Low-pass coefficient table
  //////////////////////////////////////////////////

  // Symmetric taps. Entry 0 multiplies the newest held sample
  localparam coef_t fir_coefs [N_TAPS] = '{
    20'hFFF9E,  // -0.0015
    20'hFFF86,
    20'hFFFA7,
    20'h0003B,
    20'h0014B,
    20'h0024A,
    20'h00222,
    20'hFFFE4,
    20'hFFBC5,  // Start of the negative side lobe
    20'hFF7CA,
    20'hFF74E,
    20'hFFD74,
    20'h00B1A,
    20'h01DAC,
    20'h02F9E,
    20'h03AA9,  // Center pair, about 0.229
    20'h03AA9,
    20'h02F9E,
    20'h01DAC,
    20'h00B1A,
    20'hFFD74,
    20'hFF74E,
    20'hFF7CA,
    20'hFFBC5,
    20'hFFFE4,
    20'h00222,
    20'h0024A,
    20'h0014B,
    20'h0003B,
    20'hFFFA7,
    20'hFFF86,
    20'hFFF9E
  };

endpackage
